// File: backing_ram.sv
`timescale 1ns/1ps
`default_nettype none

module backing_ram (
	input  logic                 i_clk,
	input  logic                 i_rd,
	input  logic                 i_wr,
	input  cache_pkg::ram_addr_t i_addr,
	input  mem_pkg::word_t       i_wdata,
	input  mem_pkg::strb_t       i_wstrb,
	output mem_pkg::word_t       o_rdata  // valid the cycle after i_rd
);

	mem_pkg::word_t mem [cache_pkg::RAM_WORDS];

	// byte-enable write
	always_ff @(posedge i_clk) begin
		if (i_wr) begin
			for (int b = 0; b < 4; b++) begin
				if (i_wstrb[b])
					mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
			end
		end
	end

	// registered read, holds its value between reads
	always_ff @(posedge i_clk) begin
		if (i_rd)
			o_rdata <= mem[i_addr];
	end

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int LINE_WORDS  = 4;    // words per cache line
	localparam int CACHE_LINES = 16;   // direct mapped, one way
	localparam int RAM_WORDS   = 1024; // 4 KB of backing store

	typedef logic [$clog2(LINE_WORDS)-1:0]  word_sel_t; // word within a line
	typedef logic [$clog2(CACHE_LINES)-1:0] index_t;    // line number

	// byte address bits 11:8, what is left of the 4 KB space
	typedef logic [3:0] tag_t;

	typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t; // word address into the ram

endpackage

`default_nettype wire

// File: dcache_dm.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_dm (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  mem_pkg::addr_t       i_addr,
	input  logic                 i_store_we,  // store hit update
	input  mem_pkg::word_t       i_wdata,
	input  mem_pkg::strb_t       i_wstrb,
	input  logic                 i_fill_we,   // refill word from ram
	input  logic                 i_fill_last,
	input  cache_pkg::word_sel_t i_fill_word,
	input  mem_pkg::word_t       i_fill_data,
	output logic                 o_hit,
	output mem_pkg::word_t       o_rdata
);

	cache_pkg::word_sel_t sel;
	cache_pkg::index_t    index;
	cache_pkg::tag_t      tag;

	mem_pkg::word_t  data_mem [cache_pkg::CACHE_LINES * cache_pkg::LINE_WORDS];
	cache_pkg::tag_t tag_mem  [cache_pkg::CACHE_LINES];
	logic [cache_pkg::CACHE_LINES-1:0] valid;

	// byte address split: tag | index | word | byte
	assign sel   = i_addr[3:2];
	assign index = i_addr[7:4];
	assign tag   = i_addr[11:8];

	// lookup is purely combinational
	assign o_hit   = valid[index] && (tag_mem[index] == tag);
	assign o_rdata = data_mem[{index, sel}];

	always_ff @(posedge i_clk) begin
		if (i_fill_we) begin
			data_mem[{index, i_fill_word}] <= i_fill_data;
		end else if (i_store_we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_wstrb[b])
					data_mem[{index, sel}][8*b +: 8] <= i_wdata[8*b +: 8]; // merge lane
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_fill_we && i_fill_last)
			tag_mem[index] <= tag; // new owner of the line
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			valid <= '0;
		end else if (i_fill_we) begin
			// line is half old, half new until the last word is in
			valid[index] <= i_fill_last;
		end
	end

	// the fsm never stores and refills in the same cycle
	a_one_writer: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_store_we && i_fill_we));

endmodule

`default_nettype wire

// File: mem_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_mem,
	input  logic i_write,
	input  logic i_pipeline_ready,
	input  logic i_hit,
	input  logic i_refill_last,   // counter is issuing the final word
	output logic o_done,
	output logic o_ram_rd,
	output logic o_ram_wr,
	output logic o_store_hit_we,
	output logic o_fill_we,
	output logic o_fill_last,
	output logic o_cnt_clear,
	output logic o_cnt_en,
	output logic o_refill_active
);

	typedef enum logic [1:0] {
		IDLE, LOOKUP, REFILL, REFILL_TAIL
	} state_t;

	state_t state, state_nxt;
	logic   written;      // store already went out in this LOOKUP
	logic   fill_pending; // ram data from last cycle's read is on o_rdata

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state        <= IDLE;
			written      <= 1'b0;
			fill_pending <= 1'b0;
		end else begin
			state        <= state_nxt;
			fill_pending <= o_ram_rd;
			// hold the flag while we stay in LOOKUP, drop it on the way out
			written <= (state_nxt == LOOKUP) && (written || o_ram_wr);
		end
	end

	always_comb begin
		state_nxt       = state;
		o_done          = 1'b0;
		o_ram_rd        = 1'b0;
		o_ram_wr        = 1'b0;
		o_store_hit_we  = 1'b0;
		o_cnt_clear     = 1'b0;
		o_cnt_en        = 1'b0;
		o_refill_active = 1'b0;

		case (state)
		IDLE: begin
			o_done = !i_mem; // alu ops finish right away
			if (i_mem)
				state_nxt = LOOKUP;
		end

		LOOKUP: begin
			o_done = i_write || i_hit; // stores never wait, no write-allocate
			if (i_write && !written) begin
				o_ram_wr       = 1'b1;  // write-through
				o_store_hit_we = i_hit; // cache copy only if present
			end
			if (o_done && i_pipeline_ready) begin
				state_nxt = IDLE;
			end else if (!o_done) begin
				state_nxt   = REFILL; // load miss
				o_cnt_clear = 1'b1;
			end
		end

		REFILL: begin
			o_ram_rd        = 1'b1;
			o_cnt_en        = 1'b1;
			o_refill_active = 1'b1;
			if (i_refill_last)
				state_nxt = REFILL_TAIL;
		end

		REFILL_TAIL: state_nxt = LOOKUP; // last word lands this cycle

		default: state_nxt = IDLE;
		endcase
	end

	// refill writes trail the ram reads by one cycle
	assign o_fill_we   = fill_pending;
	assign o_fill_last = fill_pending && (state == REFILL_TAIL);

	a_no_done_in_refill: assert property (@(posedge i_clk) disable iff (i_reset)
		(state inside {REFILL, REFILL_TAIL}) |-> !o_done);

	a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_ram_rd && o_ram_wr));

	// write-through happens once even if the pipeline stalls us
	a_store_once: assert property (@(posedge i_clk) disable iff (i_reset)
		o_ram_wr |=> !o_ram_wr);

endmodule

`default_nettype wire

// File: mem_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_lane_align (
	input  logic             i_mem,
	input  mem_pkg::funct3_t i_funct3,
	input  logic [1:0]       i_offset,     // byte offset within the word
	input  mem_pkg::word_t   i_store_data, // rs2
	input  mem_pkg::word_t   i_read_word,  // whole word from the cache
	output mem_pkg::word_t   o_wdata,
	output mem_pkg::strb_t   o_wstrb,
	output mem_pkg::word_t   o_load_value
);

	logic [4:0]     shamt;     // lane offset in bits
	logic           is_byte;
	logic           is_half;
	logic           zext;      // unsigned load
	mem_pkg::word_t lane_word; // addressed lane moved down to bit 0

	assign shamt   = {i_offset, 3'b000};
	assign is_byte = (i_funct3 == mem_pkg::F3_LB) || (i_funct3 == mem_pkg::F3_LBU);
	assign is_half = (i_funct3 == mem_pkg::F3_LH) || (i_funct3 == mem_pkg::F3_LHU);
	assign zext    = i_funct3[2];

	// store side, bytes above the access size get masked off by the strobe
	assign o_wdata = i_store_data << shamt;

	always_comb begin
		if (!i_mem)
			o_wstrb = '0;                   // nothing to write for alu ops
		else if (is_byte)
			o_wstrb = 4'b0001 << i_offset;
		else if (is_half)
			o_wstrb = 4'b0011 << i_offset;  // offset is 0 or 2 here
		else
			o_wstrb = 4'b1111;
	end

	// load side
	assign lane_word = i_read_word >> shamt;

	always_comb begin
		if (is_byte)
			o_load_value = {{24{!zext & lane_word[7]}}, lane_word[7:0]};
		else if (is_half)
			o_load_value = {{16{!zext & lane_word[15]}}, lane_word[15:0]};
		else
			o_load_value = lane_word; // full word, offset is zero
	end

	// the caller must never hand over a misaligned access
	always_comb begin
		if (i_mem) begin
			a_aligned: assert #0 (!(is_half && i_offset[0]) &&
				!(i_funct3 == mem_pkg::F3_LW && i_offset != 2'b00))
				else $error("misaligned access, funct3 %b offset %0d", i_funct3, i_offset);
		end
	end

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef logic [31:0] word_t;    // one data word
	typedef logic [31:0] addr_t;    // byte address, straight from the alu
	typedef logic [3:0]  strb_t;    // one enable per byte lane
	typedef logic [4:0]  reg_idx_t; // destination register
	typedef logic [2:0]  funct3_t;  // risc-v load/store width code

	// bit 2 set selects zero extension, bits 1:0 give the size
	// stores reuse the signed codes
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;

endpackage

`default_nettype wire

// File: mem_stage_top.f
mem_pkg.sv
cache_pkg.sv
mem_lane_align.sv
mem_access_fsm.sv
refill_counter.sv
dcache_dm.sv
backing_ram.sv
mem_stage_top.sv
tb_mem_stage.sv

// File: mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_pipeline_ready, // next stage takes the result
	input  logic              i_mem,            // load or store
	input  logic              i_write,          // store
	input  mem_pkg::funct3_t  i_funct3,
	input  mem_pkg::addr_t    i_addr,           // alu result
	input  mem_pkg::word_t    i_store_data,     // rs2
	input  mem_pkg::reg_idx_t i_rd_idx,
	output logic              o_done,
	output mem_pkg::word_t    o_rd_output,
	output mem_pkg::reg_idx_t o_rd_idx
);

	logic                 hit;
	logic                 ram_rd, ram_wr;
	logic                 store_hit_we;
	logic                 fill_we, fill_last;
	logic                 cnt_clear, cnt_en, cnt_last;
	logic                 refill_active;
	cache_pkg::word_sel_t cnt_word, fill_word;
	cache_pkg::ram_addr_t ram_addr;
	mem_pkg::word_t       cache_rdata, ram_rdata;
	mem_pkg::word_t       wdata, load_value, rd_next;
	mem_pkg::strb_t       wstrb;

	mem_access_fsm u_fsm (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_mem(i_mem), .i_write(i_write), .i_pipeline_ready(i_pipeline_ready),
		.i_hit(hit), .i_refill_last(cnt_last),
		.o_done(o_done), .o_ram_rd(ram_rd), .o_ram_wr(ram_wr),
		.o_store_hit_we(store_hit_we), .o_fill_we(fill_we), .o_fill_last(fill_last),
		.o_cnt_clear(cnt_clear), .o_cnt_en(cnt_en), .o_refill_active(refill_active)
	);

	refill_counter u_cnt (
		.i_clk(i_clk), .i_reset(i_reset), .i_clear(cnt_clear), .i_en(cnt_en),
		.o_word(cnt_word), .o_fill_word(fill_word), .o_last(cnt_last)
	);

	mem_lane_align u_align (
		.i_mem(i_mem), .i_funct3(i_funct3), .i_offset(i_addr[1:0]),
		.i_store_data(i_store_data), .i_read_word(cache_rdata),
		.o_wdata(wdata), .o_wstrb(wstrb), .o_load_value(load_value)
	);

	dcache_dm u_dcache (
		.i_clk(i_clk), .i_reset(i_reset), .i_addr(i_addr),
		.i_store_we(store_hit_we), .i_wdata(wdata), .i_wstrb(wstrb),
		.i_fill_we(fill_we), .i_fill_last(fill_last), .i_fill_word(fill_word),
		.i_fill_data(ram_rdata), .o_hit(hit), .o_rdata(cache_rdata)
	);

	// refill walks the line from its base, stores go to their own word
	assign ram_addr = refill_active ? {i_addr[11:4], cnt_word} : i_addr[11:2];

	backing_ram u_ram (
		.i_clk(i_clk), .i_rd(ram_rd), .i_wr(ram_wr), .i_addr(ram_addr),
		.i_wdata(wdata), .i_wstrb(wstrb), .o_rdata(ram_rdata)
	);

	assign rd_next = (i_mem && !i_write) ? load_value : i_addr; // loads return data

	// pipeline output registers, loaded when the next stage accepts
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_rd_output <= '0;
			o_rd_idx    <= '0;
		end else if (i_pipeline_ready && o_done) begin
			o_rd_output <= rd_next;
			o_rd_idx    <= i_rd_idx;
		end
	end

endmodule

`default_nettype wire

// File: refill_counter.sv
`timescale 1ns/1ps
`default_nettype none

module refill_counter (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_clear,
	input  logic                 i_en,
	output cache_pkg::word_sel_t o_word,      // word being issued to the ram
	output cache_pkg::word_sel_t o_fill_word, // word whose data arrives now
	output logic                 o_last
);

	always_ff @(posedge i_clk) begin
		if (i_reset || i_clear) begin
			o_word      <= '0;
			o_fill_word <= '0;
		end else if (i_en) begin
			o_word      <= o_word + 1'b1; // wraps after the last word
			o_fill_word <= o_word;        // ram answers one cycle later
		end
	end

	assign o_last = (o_word == cache_pkg::word_sel_t'(cache_pkg::LINE_WORDS - 1));

	// a clear never arrives together with a count request
	a_clear_alone: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_clear && i_en));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory stage testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_mem_stage -f mem_stage_top.f \
	&& ./obj_dir/Vtb_mem_stage > sim.log 2>&1 \
	|| echo "Result: FAILED" >> sim.log

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

	localparam int NUM_OPS     = 8 + 256 + 112 + 192 + 40 + 300; // ops over all tests
	localparam int WATCHDOG_NS = (NUM_OPS * 20 + 200) * 10;

	logic              i_clk, i_reset, i_pipeline_ready, i_mem, i_write;
	mem_pkg::funct3_t  i_funct3;
	mem_pkg::addr_t    i_addr;
	mem_pkg::word_t    i_store_data;
	mem_pkg::reg_idx_t i_rd_idx;
	logic              o_done;
	mem_pkg::word_t    o_rd_output;
	mem_pkg::reg_idx_t o_rd_idx;

	logic [7:0]        shadow [512];      // byte image of the test region
	logic [31:0]       rng = 32'd90;      // xorshift state
	int                value_errors = 0;
	int                other_errors = 0;
	mem_pkg::word_t    exp_q [$];         // expected results in issue order
	mem_pkg::reg_idx_t idx_q [$];
	string             name_q [$];
	logic              acc_seen = 1'b0;   // result went into the registers at the last edge
	mem_pkg::word_t    exp_val;
	mem_pkg::reg_idx_t exp_idx;
	string             exp_name;

	mem_stage_top DUT (.*);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the memory stage stopped finishing instructions");
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// little endian word from the shadow bytes
	function automatic mem_pkg::word_t shadow_word(input mem_pkg::addr_t addr);
		logic [8:0] a;
		a = {addr[8:2], 2'b00};
		return {shadow[a + 9'd3], shadow[a + 9'd2], shadow[a + 9'd1], shadow[a]};
	endfunction

	// what the result register should hold after the instruction
	function automatic mem_pkg::word_t expected_result(input logic mem, input logic write,
			input mem_pkg::funct3_t f3, input mem_pkg::addr_t addr, input mem_pkg::word_t w);
		logic [7:0]  b;
		logic [15:0] h;
		case (addr[1:0])
			2'd0: b = w[7:0];
			2'd1: b = w[15:8];
			2'd2: b = w[23:16];
			default: b = w[31:24];
		endcase
		h = addr[1] ? w[31:16] : w[15:0];
		if (!mem || write)
			return addr;                     // alu ops and stores hand the address on
		case (f3)
			mem_pkg::F3_LB:  return {{24{b[7]}}, b};
			mem_pkg::F3_LBU: return {24'd0, b};
			mem_pkg::F3_LH:  return {{16{h[15]}}, h};
			mem_pkg::F3_LHU: return {16'd0, h};
			default:         return w;
		endcase
	endfunction

	task automatic store_shadow(input mem_pkg::funct3_t f3, input mem_pkg::addr_t addr,
			input mem_pkg::word_t d);
		logic [8:0] a;
		a = addr[8:0];
		shadow[a] = d[7:0];                  // low byte of rs2 lands at the address
		if (f3[1:0] != 2'b00)
			shadow[a + 9'd1] = d[15:8];
		if (f3[1:0] == 2'b10) begin
			shadow[a + 9'd2] = d[23:16];
			shadow[a + 9'd3] = d[31:24];
		end
	endtask

	// present one instruction and hold it until the stage hands it on
	task automatic run_op(input string name, input logic mem, input logic write,
			input mem_pkg::funct3_t f3, input mem_pkg::addr_t addr, input mem_pkg::word_t d,
			input mem_pkg::reg_idx_t rd, input int stall);
		mem_pkg::word_t    held_out;
		mem_pkg::reg_idx_t held_idx;
		int                cyc;
		int                first_done;
		int                left;
		logic              accepted;
		exp_q.push_back(expected_result(mem, write, f3, addr, shadow_word(addr)));
		idx_q.push_back(rd);
		name_q.push_back(name);
		if (mem && write)
			store_shadow(f3, addr, d);       // applied once however long we stall
		i_mem            = mem;
		i_write          = write;
		i_funct3         = f3;
		i_addr           = addr;
		i_store_data     = d;
		i_rd_idx         = rd;
		i_pipeline_ready = (stall == 0);
		held_out         = o_rd_output;
		held_idx         = o_rd_idx;
		cyc              = 0;
		first_done       = -1;
		left             = stall;
		accepted         = 1'b0;
		while (!accepted) begin
			@(negedge i_clk);
			if (o_done && first_done < 0)
				first_done = cyc;
			if (!o_done && first_done >= 0) begin
				other_errors++;
				$display("%s: o_done fell before the result was taken", name);
			end
			accepted = o_done && i_pipeline_ready;
			if (!accepted) begin
				if (o_rd_output !== held_out || o_rd_idx !== held_idx) begin
					other_errors++;
					$display("%s: output registers changed before the result was taken", name);
				end
				if (o_done && left > 0)
					left = left - 1;             // back-pressure counts only once done
				@(posedge i_clk);
				#1;
				i_pipeline_ready = (left == 0);
				cyc = cyc + 1;
			end
		end
		if (!mem && first_done != 0) begin
			value_errors++;
			$display("FAIL %s done cycle: expected 0, actual %0d", name, first_done);
		end else if (mem && write && first_done != 1) begin
			value_errors++;
			$display("FAIL %s done cycle: expected 1, actual %0d", name, first_done);
		end else if (mem && !write && first_done != 1 && first_done != 7) begin
			value_errors++;
			$display("FAIL %s done cycle: expected 1 or 7, actual %0d", name, first_done);
		end
		@(posedge i_clk);
		#1;
	endtask

	// legal access anywhere in the region, or an alu op
	task automatic random_op(input string name, input int max_stall);
		logic [31:0]      r;
		logic [1:0]       size;
		logic [1:0]       off;
		int               kind;
		int               stall;
		mem_pkg::funct3_t f3;
		mem_pkg::word_t   d;
		r     = next_rand();
		d     = next_rand();
		kind  = int'(r[3:0]) % 8;            // 0..1 alu, 2..4 load, 5..7 store
		size  = (r[12:11] == 2'b11) ? 2'b10 : r[12:11];
		off   = (size == 2'b00) ? r[14:13] : ((size == 2'b01) ? {r[13], 1'b0} : 2'b00);
		f3    = {r[15] && kind < 5 && size != 2'b10, size}; // unsigned only for sub-word loads
		stall = (max_stall > 0) ? int'(r[20:16]) % (max_stall + 1) : 0;
		if (kind < 2)
			run_op(name, 1'b0, 1'b0, r[31:29], d, next_rand(), r[25:21], stall);
		else
			run_op(name, 1'b1, kind >= 5, f3, {23'd0, r[10:4], off}, d, r[25:21], stall);
	endtask

	always @(negedge i_clk) begin
		if (acc_seen) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("result registers loaded with no instruction outstanding");
			end else begin
				exp_val  = exp_q.pop_front();
				exp_idx  = idx_q.pop_front();
				exp_name = name_q.pop_front();
				if (o_rd_output !== exp_val) begin
					value_errors++;
					$display("FAIL %s: expected %h, actual %h", exp_name, exp_val, o_rd_output);
				end
				if (o_rd_idx !== exp_idx) begin
					value_errors++;
					$display("FAIL %s rd: expected %0d, actual %0d", exp_name, exp_idx, o_rd_idx);
				end
			end
		end
		acc_seen = !i_reset && o_done && i_pipeline_ready;
	end

	initial begin
		logic [31:0]    r;
		mem_pkg::addr_t a;
		i_reset          = 1'b1;
		i_pipeline_ready = 1'b0;
		i_mem            = 1'b0;
		i_write          = 1'b0;
		i_funct3         = '0;
		i_addr           = '0;
		i_store_data     = '0;
		i_rd_idx         = '0;
		repeat (2) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		for (int n = 0; n < 8; n++) begin  // alu results pass straight through
			r = next_rand();
			run_op("nonmem", 1'b0, 1'b0, r[2:0], next_rand(), next_rand(), r[7:3], 0);
		end
		for (int w = 0; w < 128; w++) begin
			r = next_rand();
			run_op("sw_fill", 1'b1, 1'b1, mem_pkg::F3_LW, 32'(w * 4), r, r[4:0], 0);
		end
		for (int w = 0; w < 128; w++)      // misses first, lines 0..15 alias with 16..31
			run_op("lw_readback", 1'b1, 1'b0, mem_pkg::F3_LW, 32'(w * 4), '0, 5'(w), 0);
		for (int n = 0; n < 16; n++) begin
			r = next_rand();
			a = {23'd0, r[6:0], 2'b00};
			for (int o = 0; o < 4; o++)
				run_op("sb_lane", 1'b1, 1'b1, mem_pkg::F3_LB, a + 32'(o), next_rand(), 5'(o), 0);
			run_op("lw_after_sb", 1'b1, 1'b0, mem_pkg::F3_LW, a, '0, r[11:7], 0);
			run_op("sh_lane", 1'b1, 1'b1, mem_pkg::F3_LH, a + 32'(2 * (n % 2)), next_rand(),
				r[16:12], 0);
			run_op("lw_after_sh", 1'b1, 1'b0, mem_pkg::F3_LW, a, '0, r[21:17], 0);
		end
		for (int n = 0; n < 16; n++) begin
			r = next_rand();
			a = {23'd0, r[6:0], 2'b00};
			for (int o = 0; o < 4; o++) begin
				run_op("lb", 1'b1, 1'b0, mem_pkg::F3_LB, a + 32'(o), '0, r[11:7], 0);
				run_op("lbu", 1'b1, 1'b0, mem_pkg::F3_LBU, a + 32'(o), '0, r[16:12], 0);
			end
			for (int o = 0; o < 4; o += 2) begin
				run_op("lh", 1'b1, 1'b0, mem_pkg::F3_LH, a + 32'(o), '0, r[21:17], 0);
				run_op("lhu", 1'b1, 1'b0, mem_pkg::F3_LHU, a + 32'(o), '0, r[26:22], 0);
			end
		end
		repeat (40) random_op("backpressure", 6);
		repeat (300) random_op("random_mix", 2);

		i_pipeline_ready = 1'b0;           // idle, nothing more gets accepted
		i_mem            = 1'b0;
		repeat (3) @(negedge i_clk);
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d results never reached the output registers", exp_q.size());
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
